//--- logic/bridge_pkg.sv
package bridge_pkg;

    // One byte from the SPI slave, tagged with its position in the frame
    typedef struct packed {
        logic [7:0] data;     // Received byte, MSB first on the wire
        logic       first;    // Opening byte since CS fell
    } rx_byte_t;

    // UART transmitter FSM states
    typedef enum logic [1:0] {
        IDLE,                 // Line high, waiting for FIFO data
        START,                // Low start bit
        DATA,                 // Eight data bits, LSB first
        STOP                  // High stop bit
    } uart_state_t;

    // Bytes per debug frame
    localparam int FRAME_LEN = 16;

    // Expected frame text, byte 0 in the top bits
    localparam logic [8*FRAME_LEN-1:0] FRAME_PATTERN = {
        "SPI debug data",     // 14 printable bytes
        8'h0D,                // CR
        8'h0A                 // LF
    };

    // Number of board LEDs driven by the scroller
    localparam int LED_COUNT = 6;

endpackage

//--- logic/spi_slave.sv
module spi_slave import bridge_pkg::*; (
    input  logic     Clock,
    input  logic     rst,
    input  logic     spi_sck,      // Raw SPI clock pin
    input  logic     spi_cs,       // Raw chip select, active low
    input  logic     spi_mosi,     // Raw master out pin
    output logic     spi_miso,     // Echo of the previous byte
    output logic     rx_valid,     // One-cycle byte strobe
    output rx_byte_t rx_byte,      // Byte plus first-of-frame tag
    output logic     cs_active     // Synchronized CS, high while selected
);

    logic [1:0] sck_sync;          // Two-flop synchronizers
    logic [1:0] cs_sync;
    logic [1:0] mosi_sync;
    logic       sck_prev;          // Delayed SCK for edge detect
    logic       sck_rise;
    logic       sck_fall;
    logic [2:0] bit_cnt;           // Bits received in current byte
    logic [6:0] rx_shift;          // First seven bits of the byte
    logic [7:0] echo_q;            // MISO shift register
    logic       first_pending;     // No byte completed since CS fell
    logic [7:0] rx_full;           // Completed byte on the 8th rise

    always_ff @(posedge Clock) begin
        if (rst) begin
            sck_sync  <= 2'b00;
            cs_sync   <= 2'b11;    // Deselected out of reset
            mosi_sync <= 2'b00;
            sck_prev  <= 1'b0;
        end else begin
            sck_sync  <= {sck_sync[0], spi_sck};
            cs_sync   <= {cs_sync[0], spi_cs};
            mosi_sync <= {mosi_sync[0], spi_mosi};
            sck_prev  <= sck_sync[1];
        end
    end

    assign cs_active = ~cs_sync[1];
    assign sck_rise  = cs_active & sck_sync[1] & ~sck_prev;  // Mode 0 sample edge
    assign sck_fall  = cs_active & ~sck_sync[1] & sck_prev;  // Mode 0 shift edge
    assign rx_full   = {rx_shift, mosi_sync[1]};

    always_ff @(posedge Clock) begin
        if (rst) begin
            bit_cnt       <= 3'd0;
            echo_q        <= 8'h00;
            first_pending <= 1'b1;
            rx_valid      <= 1'b0;
        end else begin
            rx_valid <= 1'b0;                         // Strobe by default low
            if (!cs_active) begin
                bit_cnt       <= 3'd0;                // Frame boundary
                echo_q        <= 8'h00;               // First byte echoes zero
                first_pending <= 1'b1;
            end else if (sck_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    rx_valid      <= 1'b1;
                    first_pending <= 1'b0;
                    echo_q        <= rx_full;         // Returned during next byte
                end
            end else if (sck_fall && bit_cnt != 3'd0) begin
                echo_q <= {echo_q[6:0], 1'b0};        // Next bit onto MISO
            end
        end
    end

    // Receive data path
    always_ff @(posedge Clock) begin
        if (sck_rise) begin
            rx_shift <= rx_full[6:0];
        end
        if (sck_rise && bit_cnt == 3'd7) begin
            rx_byte.data  <= rx_full;
            rx_byte.first <= first_pending;
        end
    end

    assign spi_miso = echo_q[7];   // MSB first

endmodule

//--- logic/byte_fifo.sv
module byte_fifo #(
    parameter int FIFO_DEPTH = 64              // Power of two
) (
    input  logic       Clock,
    input  logic       rst,
    input  logic       wr_en,                  // Push request
    input  logic [7:0] wr_data,
    input  logic       rd_en,                  // Pop request
    output logic [7:0] rd_data,                // Head entry, valid when not empty
    output logic       empty,
    output logic       overflow                // Sticky, a push was dropped
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [7:0]  mem [FIFO_DEPTH];
    logic [AW:0] wr_ptr;                       // Extra bit tells full from empty
    logic [AW:0] rd_ptr;
    logic        full;
    logic        do_write;
    logic        do_read;

    assign empty    = (wr_ptr == rd_ptr);
    assign full     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign do_read  = rd_en && !empty;
    assign do_write = wr_en && (!full || do_read); // Pop frees a slot this cycle
    assign rd_data  = mem[rd_ptr[AW-1:0]];     // First word falls through

    always_ff @(posedge Clock) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_en && !do_write) begin
                overflow <= 1'b1;              // Byte lost
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (do_write) begin
            mem[wr_ptr[AW-1:0]] <= wr_data;
        end
    end

endmodule

//--- logic/uart_tx.sv
module uart_tx import bridge_pkg::*; #(
    parameter int CLKS_PER_BIT = 234           // Clock cycles per UART bit
) (
    input  logic       Clock,
    input  logic       rst,
    input  logic [7:0] rd_data,                // FIFO head
    input  logic       empty,                  // FIFO has nothing to send
    output logic       rd_en,                  // One-cycle pop
    output logic       uart_txd                // Serial line, idles high
);

    localparam int CW = $clog2(CLKS_PER_BIT);

    uart_state_t   state;
    logic [CW-1:0] clk_cnt;                    // Cycles into current bit
    logic [2:0]    bit_idx;                    // Data bit being sent
    logic [7:0]    shift_q;                    // Byte in flight, LSB at bit 0
    logic          txd_q;
    logic          bit_done;

    assign bit_done = (clk_cnt == CW'(CLKS_PER_BIT - 1));
    assign rd_en    = (state == IDLE) && !empty;   // Pop as the frame starts
    assign uart_txd = txd_q;

    always_ff @(posedge Clock) begin
        if (rst) begin
            state   <= IDLE;
            clk_cnt <= '0;
            bit_idx <= 3'd0;
            txd_q   <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= 3'd0;
                    txd_q   <= 1'b1;
                    if (!empty) begin
                        state <= START;
                        txd_q <= 1'b0;             // Start bit from next cycle
                    end
                end
                START: begin
                    if (bit_done) begin
                        clk_cnt <= '0;
                        state   <= DATA;
                        txd_q   <= shift_q[0];     // LSB first
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                DATA: begin
                    if (bit_done) begin
                        clk_cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                            txd_q <= 1'b1;         // Stop bit
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                            txd_q   <= shift_q[1]; // Next bit before the shift
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                STOP: begin
                    if (bit_done) begin
                        clk_cnt <= '0;
                        state   <= IDLE;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                    txd_q <= 1'b1;
                end
            endcase
        end
    end

    // Data shift register
    always_ff @(posedge Clock) begin
        if (rd_en) begin
            shift_q <= rd_data;                    // Capture popped byte
        end else if (state == DATA && bit_done) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

endmodule

//--- logic/frame_checker.sv
module frame_checker import bridge_pkg::*; (
    input  logic     Clock,
    input  logic     rst,
    input  logic     rx_valid,             // Byte strobe from SPI slave
    input  rx_byte_t rx_byte,
    input  logic     cs_active,            // Frame in progress
    output logic     debug_match           // Full frame equals pattern
);

    localparam int IW = $clog2(FRAME_LEN + 1);

    logic [IW-1:0] idx_q;                  // Bytes seen in this frame, saturating
    logic          all_eq_q;               // Every byte so far matched
    logic [IW-1:0] idx;                    // Position of the arriving byte
    logic          prefix_ok;              // Frame still matching before this byte
    logic          byte_ok;                // Frame matching after this byte

    // Expected byte at a frame position, zero past the end
    function automatic logic [7:0] pattern_byte(input logic [IW-1:0] pos);
        logic [7:0] b;
        b = 8'h00;
        if (int'(pos) < FRAME_LEN) begin
            b = FRAME_PATTERN[8*(FRAME_LEN-1-int'(pos)) +: 8];
        end
        return b;
    endfunction

    always_comb begin
        idx       = rx_byte.first ? '0 : idx_q;     // Restart on frame opener
        prefix_ok = rx_byte.first ? 1'b1 : all_eq_q;
        byte_ok   = prefix_ok && (int'(idx) < FRAME_LEN)
                    && (rx_byte.data == pattern_byte(idx));
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            idx_q       <= '0;
            all_eq_q    <= 1'b0;
            debug_match <= 1'b0;
        end else if (!cs_active) begin
            debug_match <= 1'b0;                    // Cleared between frames
        end else if (rx_valid) begin
            all_eq_q <= byte_ok;
            if (int'(idx) < FRAME_LEN) begin
                idx_q <= idx + 1'b1;
            end else begin
                idx_q <= idx;                       // Hold past frame end
            end
            // Raised on the last byte, dropped by any extra byte
            debug_match <= byte_ok && (int'(idx) == FRAME_LEN - 1);
        end
    end

endmodule

//--- logic/led_scroll.sv
module led_scroll import bridge_pkg::*; #(
    parameter int LED_STEP = 2_700_000             // Cycles per LED position
) (
    input  logic                 Clock,
    input  logic                 rst,
    output logic [LED_COUNT-1:0] leds              // One-hot, bit 0 lit after reset
);

    localparam int SW = $clog2(LED_STEP);

    logic [SW-1:0] step_cnt;

    always_ff @(posedge Clock) begin
        if (rst) begin
            step_cnt <= '0;
            leds     <= LED_COUNT'(1);
        end else if (step_cnt == SW'(LED_STEP - 1)) begin
            step_cnt <= '0;
            leds     <= {leds[LED_COUNT-2:0], leds[LED_COUNT-1]}; // Move up, wrap to 0
        end else begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

endmodule

//--- logic/spi_uart_bridge.sv
module spi_uart_bridge import bridge_pkg::*; #(
    parameter int CLKS_PER_BIT = 234,              // UART bit period in cycles
    parameter int FIFO_DEPTH   = 64,               // Bytes buffered toward UART
    parameter int LED_STEP     = 2_700_000         // LED scroll interval
) (
    input  logic                 Clock,
    input  logic                 rst,
    input  logic                 spi_sck,
    input  logic                 spi_cs,
    input  logic                 spi_mosi,
    output logic                 spi_miso,
    output logic                 uart_txd,
    output logic [LED_COUNT-1:0] leds,
    output logic                 debug_match,      // Pattern frame seen
    output logic                 overflow          // FIFO dropped a byte
);

    logic       rx_valid;
    rx_byte_t   rx_byte;
    logic       cs_active;
    logic [7:0] fifo_rd_data;
    logic       fifo_empty;
    logic       fifo_rd_en;

    spi_slave u_spi_slave (
        .Clock     (Clock),
        .rst       (rst),
        .spi_sck   (spi_sck),
        .spi_cs    (spi_cs),
        .spi_mosi  (spi_mosi),
        .spi_miso  (spi_miso),
        .rx_valid  (rx_valid),
        .rx_byte   (rx_byte),
        .cs_active (cs_active)
    );

    byte_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_byte_fifo (
        .Clock    (Clock),
        .rst      (rst),
        .wr_en    (rx_valid),
        .wr_data  (rx_byte.data),                  // Payload only, tag not stored
        .rd_en    (fifo_rd_en),
        .rd_data  (fifo_rd_data),
        .empty    (fifo_empty),
        .overflow (overflow)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_tx (
        .Clock    (Clock),
        .rst      (rst),
        .rd_data  (fifo_rd_data),
        .empty    (fifo_empty),
        .rd_en    (fifo_rd_en),
        .uart_txd (uart_txd)
    );

    frame_checker u_frame_checker (
        .Clock       (Clock),
        .rst         (rst),
        .rx_valid    (rx_valid),
        .rx_byte     (rx_byte),
        .cs_active   (cs_active),
        .debug_match (debug_match)
    );

    led_scroll #(
        .LED_STEP (LED_STEP)
    ) u_led_scroll (
        .Clock (Clock),
        .rst   (rst),
        .leds  (leds)
    );

endmodule

//--- dv/bridge_sva.sv
module bridge_sva import bridge_pkg::*; (
    input logic                 Clock,
    input logic                 rst,
    input logic                 spi_cs,
    input logic                 debug_match,
    input logic                 uart_txd,
    input logic [LED_COUNT-1:0] leds,
    input uart_state_t          tx_state      // Transmitter FSM state
);
    timeunit 1ns;
    timeprecision 100ps;

    // Scroller keeps exactly one LED lit
    leds_onehot: assert property (@(posedge Clock) disable iff (rst)
        $onehot(leds))
        else $error("leds lost its one-hot pattern");

    // Match flag only rises inside a selected frame
    match_in_frame: assert property (@(posedge Clock) disable iff (rst)
        $rose(debug_match) |-> !spi_cs)
        else $error("debug_match rose while spi_cs was high");

    idle_line_high: assert property (@(posedge Clock) disable iff (rst)
        (tx_state == IDLE) |-> uart_txd)
        else $error("uart_txd low while the transmitter is idle");

endmodule

bind spi_uart_bridge bridge_sva u_bridge_sva (
    .Clock       (Clock),
    .rst         (rst),
    .spi_cs      (spi_cs),
    .debug_match (debug_match),
    .uart_txd    (uart_txd),
    .leds        (leds),
    .tx_state    (u_uart_tx.state)
);

//--- dv/tb_spi_uart_bridge.sv
module tb_spi_uart_bridge import bridge_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLKS_PER_BIT = 16;
    localparam int FIFO_DEPTH   = 8;
    localparam int LED_STEP     = 50;
    localparam int SCK_HALF     = 5;               // Clock cycles per SCK half-period
    localparam int BYTE_GAP     = 10;              // Idle SCK-low cycles between bytes
    localparam int ECHO_FRAMES  = 12;
    localparam int BURST_LEN    = 40;
    localparam int TOTAL_BYTES  = ECHO_FRAMES * 6 + 3 * FRAME_LEN + BURST_LEN;
    // Worst case per byte is one SPI byte plus one UART frame
    localparam int MAX_CYCLES   =
        TOTAL_BYTES * (10 * CLKS_PER_BIT + 16 * SCK_HALF + BYTE_GAP + 40) + 5000;

    logic                 Clock;
    logic                 rst;
    logic                 spi_sck;
    logic                 spi_cs;
    logic                 spi_mosi;
    logic                 spi_miso;
    logic                 uart_txd;
    logic [LED_COUNT-1:0] leds;
    logic                 debug_match;
    logic                 overflow;

    integer     seed = 16837;
    int         cycle_cnt = 0;
    logic [7:0] frame_q[$];                        // Frame being played by the master
    logic [7:0] expect_q[$];                       // Model of bytes due on the UART
    logic [7:0] uart_q[$];                         // Bytes decoded from uart_txd
    logic       match_end;                         // debug_match just before CS rose
    logic       match_any;                         // debug_match seen at any point in frame

    spi_uart_bridge #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .FIFO_DEPTH   (FIFO_DEPTH),
        .LED_STEP     (LED_STEP)
    ) u_dut (
        .Clock       (Clock),
        .rst         (rst),
        .spi_sck     (spi_sck),
        .spi_cs      (spi_cs),
        .spi_mosi    (spi_mosi),
        .spi_miso    (spi_miso),
        .uart_txd    (uart_txd),
        .leds        (leds),
        .debug_match (debug_match),
        .overflow    (overflow)
    );

    initial Clock = 1'b0;
    always #10 Clock = ~Clock;                     // 20 ns period

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Testbench failed");
        $fatal(1);
    endtask

    always @(posedge Clock) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            fail_run($sformatf("timeout: run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge Clock);
    endtask

    // SPI mode 0 master, MOSI set while SCK low, MISO read at SCK rise
    task automatic send_frame(input int gap);
        logic [7:0] miso_byte;
        logic [7:0] echo_exp;
        match_any = 1'b0;
        spi_cs = 1'b0;
        wait_cycles(SCK_HALF);
        for (int i = 0; i < frame_q.size(); i++) begin
            echo_exp = (i == 0) ? 8'h00 : frame_q[i-1];   // Previous byte of this frame
            for (int b = 7; b >= 0; b--) begin
                spi_mosi = frame_q[i][b];
                wait_cycles(SCK_HALF);
                spi_sck      = 1'b1;
                miso_byte[b] = spi_miso;
                match_any    = match_any | debug_match;
                wait_cycles(SCK_HALF);
                spi_sck = 1'b0;
            end
            assert (miso_byte == echo_exp) else fail_run($sformatf(
                "mismatch at %0t: MISO byte %0d got %h expected %h",
                $time, i, miso_byte, echo_exp));
            wait_cycles(gap);
        end
        wait_cycles(SCK_HALF);
        match_end = debug_match;
        match_any = match_any | debug_match;
        spi_cs    = 1'b1;
        wait_cycles(8);                            // CS rise crosses the synchronizer
        assert (debug_match == 1'b0) else fail_run($sformatf(
            "mismatch at %0t: debug_match still high after CS rose", $time));
    endtask

    // Decode 8N1 frames at mid-bit
    always begin : uart_monitor
        logic [7:0] data;
        @(negedge uart_txd);
        if (!rst) begin
            repeat (CLKS_PER_BIT / 2) @(negedge Clock);
            assert (uart_txd == 1'b0) else fail_run($sformatf(
                "mismatch at %0t: UART start bit not low at mid-bit", $time));
            for (int b = 0; b < 8; b++) begin
                repeat (CLKS_PER_BIT) @(negedge Clock);
                data[b] = uart_txd;                // LSB first
            end
            repeat (CLKS_PER_BIT) @(negedge Clock);
            assert (uart_txd == 1'b1) else fail_run($sformatf(
                "mismatch at %0t: UART stop bit not high", $time));
            uart_q.push_back(data);
        end
    end

    task automatic drain_and_compare();
        logic [7:0] got;
        logic [7:0] exp;
        while (uart_q.size() < expect_q.size()) @(negedge Clock);
        while (expect_q.size() > 0) begin
            got = uart_q.pop_front();
            exp = expect_q.pop_front();
            assert (got == exp) else fail_run($sformatf(
                "mismatch at %0t: UART byte got %h expected %h", $time, got, exp));
        end
    endtask

    // Line idle for longer than a frame means the FIFO ran dry
    task automatic wait_uart_quiet();
        int quiet;
        quiet = 0;
        while (quiet < 12 * CLKS_PER_BIT) begin
            @(negedge Clock);
            quiet = uart_txd ? quiet + 1 : 0;
        end
    endtask

    task automatic load_pattern();
        frame_q.delete();
        for (int i = 0; i < FRAME_LEN; i++) begin
            frame_q.push_back(FRAME_PATTERN[8*(FRAME_LEN-1-i) +: 8]);
        end
    endtask

    task automatic queue_expected();
        foreach (frame_q[i]) expect_q.push_back(frame_q[i]);
    endtask

    function automatic int led_pos(input logic [LED_COUNT-1:0] v);
        int p;
        p = -1;
        for (int i = 0; i < LED_COUNT; i++) begin
            if (v[i]) p = i;
        end
        return p;
    endfunction

    always @(negedge Clock) begin
        if (!rst) begin
            assert ($onehot(leds)) else fail_run($sformatf(
                "mismatch at %0t: leds %b is not one-hot", $time, leds));
        end
    end

    // Successive samples one LED_STEP apart advance by one position
    initial begin : led_check
        int prev;
        int cur;
        @(negedge rst);
        prev = led_pos(leds);
        forever begin
            wait_cycles(LED_STEP);
            cur = led_pos(leds);
            assert (cur == (prev + 1) % LED_COUNT) else fail_run($sformatf(
                "mismatch at %0t: LED position %0d after %0d", $time, cur, prev));
            prev = cur;
        end
    end

    initial begin : main
        int len;
        int idx;
        int pos;
        rst      = 1'b1;
        spi_sck  = 1'b0;
        spi_cs   = 1'b1;
        spi_mosi = 1'b0;
        repeat (3) @(posedge Clock);
        @(negedge Clock);
        rst = 1'b0;
        wait_cycles(5);

        for (int f = 0; f < ECHO_FRAMES; f++) begin      // Random echo frames
            frame_q.delete();
            len = 1 + int'($unsigned($random(seed)) % 6);
            for (int k = 0; k < len; k++) frame_q.push_back(8'($random(seed)));
            queue_expected();
            send_frame(BYTE_GAP);
            drain_and_compare();
        end
        assert (overflow == 1'b0) else fail_run($sformatf(
            "mismatch at %0t: overflow set during paced traffic", $time));

        load_pattern();                                   // Exact pattern frame
        queue_expected();
        send_frame(BYTE_GAP);
        assert (match_end == 1'b1) else fail_run($sformatf(
            "mismatch at %0t: debug_match low after pattern frame", $time));
        drain_and_compare();

        load_pattern();                                   // One corrupted byte
        idx = int'($unsigned($random(seed)) % FRAME_LEN);
        frame_q[idx] = frame_q[idx] ^ (8'($random(seed)) | 8'h01);
        queue_expected();
        send_frame(BYTE_GAP);
        assert (match_any == 1'b0) else fail_run($sformatf(
            "mismatch at %0t: debug_match high with byte %0d corrupted", $time, idx));
        drain_and_compare();

        load_pattern();                                   // Pattern minus the LF
        void'(frame_q.pop_back());
        queue_expected();
        send_frame(BYTE_GAP);
        assert (match_any == 1'b0) else fail_run($sformatf(
            "mismatch at %0t: debug_match high on a 15-byte prefix", $time));
        drain_and_compare();

        frame_q.delete();                                 // Burst past FIFO capacity
        for (int k = 0; k < BURST_LEN; k++) frame_q.push_back(8'($random(seed)));
        send_frame(0);
        wait_uart_quiet();
        assert (overflow == 1'b1) else fail_run($sformatf(
            "mismatch at %0t: overflow low after burst", $time));
        assert (uart_q.size() > 0 && uart_q[0] == frame_q[0]) else fail_run($sformatf(
            "mismatch at %0t: burst output does not start with first byte", $time));
        pos = 0;
        foreach (uart_q[k]) begin
            while (pos < frame_q.size() && frame_q[pos] != uart_q[k]) pos++;
            assert (pos < frame_q.size()) else fail_run($sformatf(
                "mismatch at %0t: UART byte %0d (%h) out of burst order", $time, k, uart_q[k]));
            pos++;
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- tb.f
logic/bridge_pkg.sv
logic/spi_slave.sv
logic/byte_fifo.sv
logic/uart_tx.sv
logic/frame_checker.sv
logic/led_scroll.sv
logic/spi_uart_bridge.sv
dv/bridge_sva.sv
dv/tb_spi_uart_bridge.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_spi_uart_bridge
SEED      ?= 1
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
PASS_TEXT := Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP SEED FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -q "$(PASS_TEXT)"; then \
		exit 0; \
	else \
		echo "simulation did not report a pass"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
